/* verilog/sdram_pkg.sv */
`default_nettype none

package sdram_pkg;

	// ==============================
	// Chip commands and mode
	// ==============================

	// Bit order is cs_n, ras_n, cas_n, we_n.
	typedef enum logic [3:0] {
		CMD_NOP       = 4'b0111,
		CMD_PRECHARGE = 4'b0010,
		CMD_SET_MODE  = 4'b0000,
		CMD_REFRESH   = 4'b0001,
		CMD_ACTIVATE  = 4'b0011,
		CMD_READ      = 4'b0101,
		CMD_WRITE     = 4'b0100
	} sdram_cmd_t;

	localparam logic       WBM_PROGRAMMED   = 1'b0;    // Burst read and burst write.
	localparam logic [2:0] CAS_2            = 3'b010;
	localparam logic       BURST_SEQUENTIAL = 1'b0;
	localparam logic [2:0] BURST_2          = 3'b001;

	localparam logic [12:0] MODE_WORD =
		{3'b000, WBM_PROGRAMMED, 2'b00, CAS_2, BURST_SEQUENTIAL, BURST_2};

	localparam int CAS_LATENCY = 2;

	// Cycle counts between a command and the next one.
	localparam int T_RP  = 2;    // Precharge.
	localparam int T_RFC = 8;    // Auto refresh.
	localparam int T_MRD = 2;    // Mode register set.
	localparam int T_RCD = 2;    // Activate to read or write.

	// ==============================
	// Shared structs
	// ==============================

	typedef struct packed {
		logic        rw;         // 1 is write.
		logic [24:0] address;    // Byte address, 4 byte aligned.
		logic [31:0] wdata;
		logic [3:0]  wmask;      // Bit n enables byte n.
	} mem_req_t;

	// Bytes travel swapped inside each halfword on DQ.
	typedef struct packed {
		logic        cke;
		sdram_cmd_t  cmd;
		logic [1:0]  ba;
		logic [12:0] addr;
		logic [1:0]  dqm;        // High masks the lane.
		logic [15:0] wdata;
		logic        data_oe;
	} sdram_pins_t;

	typedef enum logic [1:0] {
		ROW_HIT,
		ROW_CLOSED,
		ROW_CONFLICT
	} row_state_t;

	// Address split.
	function automatic logic [8:0] col_of(input logic [24:0] address);
		return {address[9:2], 1'b0};    // Word column, even beat.
	endfunction

	function automatic logic [1:0] bank_of(input logic [24:0] address);
		return address[11:10];
	endfunction

	function automatic logic [12:0] row_of(input logic [24:0] address);
		return address[24:12];
	endfunction

endpackage

`default_nettype wire

/* verilog/sdram_refresh_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_refresh_timer #(
	parameter int REFRESH_INTERVAL = 780
) (
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_refresh_ack,
	output logic o_pending
);
	localparam int CW = $clog2(REFRESH_INTERVAL);
	localparam logic [CW-1:0] RELOAD = CW'(REFRESH_INTERVAL - 1);

	logic [CW-1:0] count;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count <= RELOAD;
			o_pending <= 1'b0;
		end else begin
			if (count == '0) begin
				count <= RELOAD;
				o_pending <= 1'b1;    // Wrap wins over an ack.
			end else begin
				count <= count - 1'b1;
				if (i_refresh_ack) begin
					o_pending <= 1'b0;
				end
			end
		end
	end

	// Controller only takes a refresh that was asked for.
	ack_needs_pending: assert property (@(posedge i_clock) disable iff (i_reset)
		i_refresh_ack |-> o_pending)
		else $error("refresh ack without a pending refresh");

endmodule

`default_nettype wire

/* verilog/sdram_row_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_row_tracker (
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  logic                  i_open,
	input  logic                  i_close_all,
	input  logic [1:0]            i_bank,
	input  logic [12:0]           i_row,
	output sdram_pkg::row_state_t o_row_state,
	output logic                  o_any_open
);
	logic [3:0]  valid;          // One open flag per bank.
	logic [12:0] rows [4];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			valid <= '0;
		end else if (i_close_all) begin
			valid <= '0;
		end else if (i_open) begin
			valid[i_bank] <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_open) begin
			rows[i_bank] <= i_row;
		end
	end

	// Classify the current request.
	always_comb begin
		if (!valid[i_bank]) begin
			o_row_state = sdram_pkg::ROW_CLOSED;
		end else if (rows[i_bank] == i_row) begin
			o_row_state = sdram_pkg::ROW_HIT;
		end else begin
			o_row_state = sdram_pkg::ROW_CONFLICT;
		end
	end

	assign o_any_open = |valid;

	// Activate and refresh precharge come from different controller states.
	open_close_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_open && i_close_all))
		else $error("row open and close all in the same cycle");

endmodule

`default_nettype wire

/* verilog/sdram_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_controller #(
	parameter int STARTUP_CYCLES = 20000
) (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_request,
	input  logic                   i_refresh_pending,
	input  sdram_pkg::mem_req_t    i_req,
	input  sdram_pkg::row_state_t  i_row_state,
	input  logic                   i_any_open,
	input  logic [15:0]            i_dq,
	output logic [31:0]            o_rdata,
	output logic                   o_ready,
	output logic                   o_refresh_ack,
	output logic                   o_open,
	output logic                   o_close_all,
	output sdram_pkg::sdram_pins_t o_pins
);
	// A wait of N in ST_WAIT gives N + 2 cycles between commands.
	localparam logic [15:0] CKE_ON    = 16'(STARTUP_CYCLES * 3 / 4);
	localparam logic [15:0] WAIT_RP   = 16'(sdram_pkg::T_RP - 2);
	localparam logic [15:0] WAIT_RFC  = 16'(sdram_pkg::T_RFC - 2);
	localparam logic [15:0] WAIT_MRD  = 16'(sdram_pkg::T_MRD - 2);
	localparam logic [15:0] WAIT_RCD  = 16'(sdram_pkg::T_RCD - 2);
	localparam logic [15:0] READ_SPAN = 16'(sdram_pkg::CAS_LATENCY + 3);
	localparam logic [12:0] ADDR_ALL_BANKS = 13'h0400;    // A10 high.

	typedef enum logic [3:0] {
		ST_STARTUP,
		ST_INIT_PRECHARGE,
		ST_INIT_REFRESH,
		ST_INIT_MODE,
		ST_WAIT,
		ST_IDLE,
		ST_REFRESH,
		ST_ACTIVATE,
		ST_ACCESS,
		ST_WRITE,
		ST_READ,
		ST_DONE
	} state_t;

	state_t              state;
	state_t              next_state;    // Target of ST_WAIT.
	logic [15:0]         count;
	logic                init_second;
	sdram_pkg::mem_req_t req_q;
	logic [15:0]         dq_r1;
	logic [15:0]         dq_r2;

	// ==============================
	// Command sequencer
	// ==============================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_STARTUP;
			next_state <= ST_IDLE;
			count <= 16'(STARTUP_CYCLES - 1);
			init_second <= 1'b0;
			o_ready <= 1'b0;
			o_refresh_ack <= 1'b0;
			o_open <= 1'b0;
			o_close_all <= 1'b0;
			o_pins <= '{cke: 1'b0, cmd: sdram_pkg::CMD_NOP, ba: 2'b00, addr: '0,
				dqm: 2'b11, wdata: '0, data_oe: 1'b0};
		end else begin
			o_pins.cmd <= sdram_pkg::CMD_NOP;
			o_pins.data_oe <= 1'b0;
			o_refresh_ack <= 1'b0;
			o_open <= 1'b0;
			o_close_all <= 1'b0;

			case (state)
			ST_STARTUP: begin
				count <= count - 1'b1;
				if (count <= CKE_ON) begin    // First quarter done.
					o_pins.cke <= 1'b1;
					o_pins.dqm <= 2'b00;
				end
				if (count == '0) begin
					state <= ST_INIT_PRECHARGE;
				end
			end
			ST_INIT_PRECHARGE: begin
				o_pins.cmd <= sdram_pkg::CMD_PRECHARGE;
				o_pins.addr <= ADDR_ALL_BANKS;
				count <= WAIT_RP;
				next_state <= ST_INIT_REFRESH;
				state <= ST_WAIT;
			end
			ST_INIT_REFRESH: begin
				// Entered twice.
				o_pins.cmd <= sdram_pkg::CMD_REFRESH;
				init_second <= 1'b1;
				count <= WAIT_RFC;
				next_state <= init_second ? ST_INIT_MODE : ST_INIT_REFRESH;
				state <= ST_WAIT;
			end
			ST_INIT_MODE: begin
				o_pins.cmd <= sdram_pkg::CMD_SET_MODE;
				o_pins.ba <= 2'b00;
				o_pins.addr <= sdram_pkg::MODE_WORD;
				count <= WAIT_MRD;
				next_state <= ST_IDLE;
				state <= ST_WAIT;
			end
			ST_WAIT: begin
				if (count == '0) begin
					state <= next_state;
				end else begin
					count <= count - 1'b1;
				end
			end
			ST_IDLE: begin
				if (i_refresh_pending) begin
					o_refresh_ack <= 1'b1;
					if (i_any_open) begin
						// Rows cannot stay open across a refresh.
						o_pins.cmd <= sdram_pkg::CMD_PRECHARGE;
						o_pins.addr <= ADDR_ALL_BANKS;
						o_close_all <= 1'b1;
						count <= WAIT_RP;
						next_state <= ST_REFRESH;
						state <= ST_WAIT;
					end else begin
						state <= ST_REFRESH;
					end
				end else if (i_request) begin
					case (i_row_state)
					sdram_pkg::ROW_HIT: state <= ST_ACCESS;
					sdram_pkg::ROW_CLOSED: state <= ST_ACTIVATE;
					default: begin
						// Close the other row in this bank.
						o_pins.cmd <= sdram_pkg::CMD_PRECHARGE;
						o_pins.ba <= sdram_pkg::bank_of(i_req.address);
						o_pins.addr <= '0;
						count <= WAIT_RP;
						next_state <= ST_ACTIVATE;
						state <= ST_WAIT;
					end
					endcase
				end
			end
			ST_REFRESH: begin
				o_pins.cmd <= sdram_pkg::CMD_REFRESH;
				count <= WAIT_RFC;
				next_state <= ST_IDLE;
				state <= ST_WAIT;
			end
			ST_ACTIVATE: begin
				o_pins.cmd <= sdram_pkg::CMD_ACTIVATE;
				o_pins.ba <= sdram_pkg::bank_of(req_q.address);
				o_pins.addr <= sdram_pkg::row_of(req_q.address);
				o_open <= 1'b1;
				count <= WAIT_RCD;
				next_state <= ST_ACCESS;
				state <= ST_WAIT;
			end
			ST_ACCESS: begin
				o_pins.ba <= sdram_pkg::bank_of(req_q.address);
				o_pins.addr <= {4'b0000, sdram_pkg::col_of(req_q.address)};    // A10 low.
				if (req_q.rw) begin
					// Beat 0 is the upper halfword.
					o_pins.cmd <= sdram_pkg::CMD_WRITE;
					o_pins.wdata <= {req_q.wdata[23:16], req_q.wdata[31:24]};
					o_pins.dqm <= ~{req_q.wmask[2], req_q.wmask[3]};
					o_pins.data_oe <= 1'b1;
					state <= ST_WRITE;
				end else begin
					o_pins.cmd <= sdram_pkg::CMD_READ;
					o_pins.dqm <= 2'b00;
					count <= READ_SPAN;
					state <= ST_READ;
				end
			end
			ST_WRITE: begin
				o_pins.wdata <= {req_q.wdata[7:0], req_q.wdata[15:8]};
				o_pins.dqm <= ~{req_q.wmask[0], req_q.wmask[1]};
				o_pins.data_oe <= 1'b1;
				o_ready <= 1'b1;
				state <= ST_DONE;
			end
			ST_READ: begin
				if (count == '0) begin
					o_ready <= 1'b1;    // Lower beat lands this edge.
					state <= ST_DONE;
				end else begin
					count <= count - 1'b1;
				end
			end
			ST_DONE: begin
				o_pins.dqm <= 2'b00;
				if (!i_request) begin
					o_ready <= 1'b0;
					state <= ST_IDLE;
				end
			end
			default: state <= ST_STARTUP;
			endcase
		end
	end

	// ==============================
	// Request and read data path
	// ==============================

	always_ff @(posedge i_clock) begin
		if (state == ST_IDLE) begin
			req_q <= i_req;    // Holds the value taken at dispatch.
		end
	end

	// Chip drives beat 0 for the edge CAS_LATENCY after the one that takes READ.
	always_ff @(posedge i_clock) begin
		dq_r1 <= i_dq;
		dq_r2 <= dq_r1;
		if (state == ST_READ && count == 16'd1) begin
			o_rdata[31:16] <= {dq_r2[7:0], dq_r2[15:8]};
		end
		if (state == ST_READ && count == '0) begin
			o_rdata[15:0] <= {dq_r2[7:0], dq_r2[15:8]};
		end
	end

	nop_while_cke_low: assert property (@(posedge i_clock) disable iff (i_reset)
		!o_pins.cke |-> o_pins.cmd == sdram_pkg::CMD_NOP)
		else $error("command issued while cke is low");

	// The request is sampled on the edge that sets o_ready.
	ready_needs_request: assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(o_ready) |-> $past(i_request))
		else $error("o_ready rose without a request");

endmodule

`default_nettype wire

/* verilog/sdram_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_subsystem #(
	parameter int STARTUP_CYCLES   = 20000,
	parameter int REFRESH_INTERVAL = 780
) (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_request,
	input  sdram_pkg::mem_req_t    i_req,
	output logic [31:0]            o_rdata,
	output logic                   o_ready,
	output logic                   o_sdram_clk,
	output sdram_pkg::sdram_pins_t o_pins,
	input  logic [15:0]            i_dq
);
	logic                  refresh_pending;
	logic                  refresh_ack;
	logic                  row_open;
	logic                  close_all;
	logic                  any_open;
	sdram_pkg::row_state_t row_state;

	assign o_sdram_clk = i_clock;    // No phase offset.

	sdram_refresh_timer #(
		.REFRESH_INTERVAL(REFRESH_INTERVAL)
	) u_refresh_timer (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_refresh_ack (refresh_ack),
		.o_pending     (refresh_pending)
	);

	// Request fields stay stable until o_ready, so the tracker sees them at activate.
	sdram_row_tracker u_row_tracker (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_open      (row_open),
		.i_close_all (close_all),
		.i_bank      (sdram_pkg::bank_of(i_req.address)),
		.i_row       (sdram_pkg::row_of(i_req.address)),
		.o_row_state (row_state),
		.o_any_open  (any_open)
	);

	sdram_controller #(
		.STARTUP_CYCLES(STARTUP_CYCLES)
	) u_controller (
		.i_clock           (i_clock),
		.i_reset           (i_reset),
		.i_request         (i_request),
		.i_refresh_pending (refresh_pending),
		.i_req             (i_req),
		.i_row_state       (row_state),
		.i_any_open        (any_open),
		.i_dq              (i_dq),
		.o_rdata           (o_rdata),
		.o_ready           (o_ready),
		.o_refresh_ack     (refresh_ack),
		.o_open            (row_open),
		.o_close_all       (close_all),
		.o_pins            (o_pins)
	);

endmodule

`default_nettype wire

/* sim/sdram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
	input  logic                   i_clock,
	input  sdram_pkg::sdram_pins_t i_pins,
	output logic [15:0]            o_dq
);
	logic [15:0] mem [logic [23:0]];    // Key is bank, row, column.
	logic [3:0]  bank_open = '0;
	logic [12:0] open_row [4];
	logic [23:0] rd_key;
	logic [23:0] wr_key;
	int          rd_timer = 0;
	logic        wr_next = 1'b0;
	logic        mode_set = 1'b0;
	int          refresh_count = 0;
	int          error_count = 0;

	initial o_dq = '0;

	function automatic logic [23:0] key_of(input logic [1:0] bank, input logic [8:0] col);
		return {bank, open_row[bank], col};
	endfunction

	function automatic logic [15:0] read_half(input logic [23:0] key);
		return mem.exists(key) ? mem[key] : 16'h0000;
	endfunction

	// DQM high keeps the stored byte.
	task automatic write_half(input logic [23:0] key, input logic [15:0] data,
		input logic [1:0] dqm);
		logic [15:0] word;
		word = read_half(key);
		if (!dqm[1]) word[15:8] = data[15:8];
		if (!dqm[0]) word[7:0] = data[7:0];
		mem[key] = word;
	endtask

	always @(posedge i_clock) begin
		if (wr_next) begin
			write_half(wr_key, i_pins.wdata, i_pins.dqm);    // Second beat.
		end
		wr_next <= 1'b0;
		if (rd_timer == 2) begin
			o_dq <= read_half(rd_key);
		end else if (rd_timer == 1) begin
			o_dq <= read_half(rd_key | 24'd1);
		end
		if (rd_timer != 0) rd_timer <= rd_timer - 1;
		if (i_pins.cke) begin
			case (i_pins.cmd)
			sdram_pkg::CMD_ACTIVATE: begin
				bank_open[i_pins.ba] <= 1'b1;
				open_row[i_pins.ba] <= i_pins.addr;
			end
			sdram_pkg::CMD_PRECHARGE: begin
				if (i_pins.addr[10]) bank_open <= '0;    // All banks.
				else bank_open[i_pins.ba] <= 1'b0;
			end
			sdram_pkg::CMD_REFRESH: refresh_count <= refresh_count + 1;
			sdram_pkg::CMD_SET_MODE: mode_set <= 1'b1;
			sdram_pkg::CMD_WRITE: begin
				write_half(key_of(i_pins.ba, i_pins.addr[8:0]), i_pins.wdata, i_pins.dqm);
				wr_key <= key_of(i_pins.ba, i_pins.addr[8:0] | 9'd1);
				wr_next <= 1'b1;
			end
			sdram_pkg::CMD_READ: begin
				rd_key <= key_of(i_pins.ba, i_pins.addr[8:0]);
				rd_timer <= sdram_pkg::CAS_LATENCY;
			end
			default: ;
			endcase
		end
	end

	// ==============================
	// Command order rules
	// ==============================

	activate_closed_bank: assert property (@(posedge i_clock)
		i_pins.cke && i_pins.cmd == sdram_pkg::CMD_ACTIVATE |-> !bank_open[i_pins.ba])
		else begin
			error_count = error_count + 1;
			$display("Model: ACTIVATE issued to a bank that is already open");
		end

	access_open_bank: assert property (@(posedge i_clock)
		i_pins.cke && (i_pins.cmd == sdram_pkg::CMD_READ || i_pins.cmd == sdram_pkg::CMD_WRITE)
		|-> bank_open[i_pins.ba])
		else begin
			error_count = error_count + 1;
			$display("Model: READ or WRITE issued to a closed bank");
		end

	refresh_all_closed: assert property (@(posedge i_clock)
		i_pins.cke && i_pins.cmd == sdram_pkg::CMD_REFRESH |-> bank_open == 4'b0000)
		else begin
			error_count = error_count + 1;
			$display("Model: REFRESH issued while a bank is still open");
		end

	mode_word_value: assert property (@(posedge i_clock)
		i_pins.cke && i_pins.cmd == sdram_pkg::CMD_SET_MODE |-> i_pins.addr == sdram_pkg::MODE_WORD)
		else begin
			error_count = error_count + 1;
			$display("Model: mode register written with a wrong value");
		end

	// DQ is driven for the two write beats and at no other time.
	data_oe_on_write_beats: assert property (@(posedge i_clock)
		i_pins.cke |->
		i_pins.data_oe == ((i_pins.cmd == sdram_pkg::CMD_WRITE) || wr_next))
		else begin
			error_count = error_count + 1;
			$display("Model: data_oe does not match the write beats");
		end

endmodule

`default_nettype wire

/* sim/tb_sdram.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sdram;
	localparam int STARTUP_CYCLES   = 100;
	localparam int REFRESH_INTERVAL = 300;
	localparam int TIMEOUT_CYCLES   = 2000;

	logic                   i_clock;
	logic                   i_reset;
	logic                   i_request;
	sdram_pkg::mem_req_t    i_req;
	logic [31:0]            o_rdata;
	logic                   o_ready;
	logic                   sdram_clk;
	sdram_pkg::sdram_pins_t pins;
	logic [15:0]            dq;

	logic [31:0] shadow [logic [22:0]];    // Word address to expected data.
	logic [31:0] rng_state;
	int          tb_errors;
	int          tests_run;
	int          tests_failed;
	int          errors_before;

	sdram_subsystem #(
		.STARTUP_CYCLES   (STARTUP_CYCLES),
		.REFRESH_INTERVAL (REFRESH_INTERVAL)
	) dut (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_request   (i_request),
		.i_req       (i_req),
		.o_rdata     (o_rdata),
		.o_ready     (o_ready),
		.o_sdram_clk (sdram_clk),
		.o_pins      (pins),
		.i_dq        (dq)
	);

	sdram_model u_chip (
		.i_clock (sdram_clk),
		.i_pins  (pins),
		.o_dq    (dq)
	);

	initial begin
		i_clock = 1'b0;
		forever begin
			#20 i_clock = ~i_clock;
		end
	end

	// ==============================
	// Helpers
	// ==============================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Row, bank and column word packed into a byte address.
	function automatic logic [24:0] make_addr(input logic [12:0] row, input logic [1:0] bank,
		input logic [7:0] col_word);
		return {row, bank, col_word, 2'b00};
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] mask);
		logic [31:0] result;
		result = old_word;
		for (int n = 0; n < 4; n++) begin
			if (mask[n]) result[8*n +: 8] = new_word[8*n +: 8];
		end
		return result;
	endfunction

	function automatic logic [31:0] shadow_read(input logic [24:0] address);
		return shadow.exists(address[24:2]) ? shadow[address[24:2]] : 32'h0;
	endfunction

	function automatic int total_errors();
		return tb_errors + u_chip.error_count;
	endfunction

	task automatic abort_run(input string what);
		$display("Timeout: %s", what);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	task automatic begin_test();
		errors_before = total_errors();
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (total_errors() > errors_before) begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, total_errors() - errors_before);
		end else begin
			$display("Test %s: ok", name);
		end
	endtask

	// Holds the request level until o_ready, then drops it and waits for idle.
	task automatic run_request(input string name, input logic rw, input logic [24:0] address,
		input logic [31:0] wdata, input logic [3:0] wmask, output logic [31:0] rdata);
		int cycles;
		@(posedge i_clock);
		#2;
		i_req = '{rw: rw, address: address, wdata: wdata, wmask: wmask};
		i_request = 1'b1;
		cycles = 0;
		while (!o_ready) begin
			@(posedge i_clock);
			#2;
			cycles++;
			if (cycles > TIMEOUT_CYCLES) abort_run({"o_ready never rose in test ", name});
		end
		rdata = o_rdata;
		i_request = 1'b0;
		cycles = 0;
		while (o_ready) begin
			@(posedge i_clock);
			#2;
			cycles++;
			if (cycles > TIMEOUT_CYCLES) abort_run({"o_ready never fell in test ", name});
		end
	endtask

	task automatic write_word(input string name, input logic [24:0] address,
		input logic [31:0] data, input logic [3:0] mask);
		logic [31:0] rdata;
		run_request(name, 1'b1, address, data, mask, rdata);
		shadow[address[24:2]] = merge_bytes(shadow_read(address), data, mask);
	endtask

	task automatic read_check(input string name, input logic [24:0] address);
		logic [31:0] rdata;
		logic [31:0] expected;
		run_request(name, 1'b0, address, 32'h0, 4'h0, rdata);
		expected = shadow_read(address);
		assert (rdata === expected) else begin
			$display("Error: test %s address %h expected %h actual %h",
				name, address, expected, rdata);
			tb_errors++;
		end
	endtask

	// cke and masked DQM stay for the first quarter of startup.
	task automatic check_init();
		int cycles;
		cycles = 0;
		while (!pins.cke) begin
			assert (!o_ready && pins.cmd == sdram_pkg::CMD_NOP && pins.dqm == 2'b11) else begin
				$display("Test init: command, o_ready or open DQM seen while cke is low");
				tb_errors++;
			end
			@(posedge i_clock);
			#2;
			cycles++;
			if (cycles > TIMEOUT_CYCLES) abort_run("cke never rose after reset");
		end
		assert (cycles >= STARTUP_CYCLES / 4) else begin
			$display("Error: test init cke low cycles expected %0d actual %0d",
				STARTUP_CYCLES / 4, cycles);
			tb_errors++;
		end
		write_word("init", make_addr(13'd0, 2'd0, 8'd0), 32'h1234_5678, 4'hf);
		assert (u_chip.mode_set) else begin
			$display("Test init: the mode register was never written");
			tb_errors++;
		end
	endtask

	task automatic random_traffic();
		logic [24:0] address;
		logic [31:0] data;
		logic [31:0] bits;
		for (int i = 0; i < 40; i++) begin
			rng_state = xorshift32(rng_state);
			bits = rng_state;
			rng_state = xorshift32(rng_state);
			data = rng_state;
			address = make_addr({12'd0, bits[1]}, bits[3:2], {6'd0, bits[5:4]});
			if (bits[0]) write_word("random", address, data, bits[9:6]);
			else read_check("random", address);
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		int refreshes_before;
		i_reset = 1'b1;
		i_request = 1'b0;
		i_req = '0;
		rng_state = 32'd11;
		tb_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (5) @(posedge i_clock);
		#2;
		i_reset = 1'b0;

		begin_test();
		check_init();
		finish_test("init");

		begin_test();
		write_word("write_read", 25'h000_1008, 32'hDEAD_BEEF, 4'hf);
		read_check("write_read", 25'h000_1008);
		finish_test("write_read");

		begin_test();
		write_word("byte_mask", 25'h000_1008, 32'hA1B2_C3D4, 4'b0101);
		read_check("byte_mask", 25'h000_1008);
		finish_test("byte_mask");

		begin_test();    // Two rows of bank 1 force precharges.
		write_word("row_conflict", make_addr(13'd3, 2'd1, 8'd5), 32'h1111_AAAA, 4'hf);
		write_word("row_conflict", make_addr(13'd7, 2'd1, 8'd5), 32'h2222_BBBB, 4'hf);
		write_word("row_conflict", make_addr(13'd3, 2'd2, 8'd9), 32'h3333_CCCC, 4'hf);
		read_check("row_conflict", make_addr(13'd3, 2'd1, 8'd5));
		write_word("row_conflict", make_addr(13'd100, 2'd3, 8'd0), 32'h4444_DDDD, 4'hf);
		read_check("row_conflict", make_addr(13'd7, 2'd1, 8'd5));
		read_check("row_conflict", make_addr(13'd3, 2'd2, 8'd9));
		read_check("row_conflict", make_addr(13'd100, 2'd3, 8'd0));
		finish_test("row_conflict");

		begin_test();
		write_word("refresh", make_addr(13'd12, 2'd0, 8'd1), 32'h5A5A_0F0F, 4'hf);
		refreshes_before = u_chip.refresh_count;
		for (int i = 0; i < 2 * REFRESH_INTERVAL + 20; i++) begin
			@(posedge i_clock);
		end
		assert (u_chip.refresh_count > refreshes_before) else begin
			$display("Error: test refresh count expected above %0d actual %0d",
				refreshes_before, u_chip.refresh_count);
			tb_errors++;
		end
		read_check("refresh", make_addr(13'd12, 2'd0, 8'd1));
		finish_test("refresh");

		begin_test();
		random_traffic();
		finish_test("random");

		$display("Tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, total_errors());
		if (tests_failed == 0 && total_errors() == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
verilog/sdram_pkg.sv
verilog/sdram_refresh_timer.sv
verilog/sdram_row_tracker.sv
verilog/sdram_controller.sv
verilog/sdram_subsystem.sv
sim/sdram_model.sv
sim/tb_sdram.sv

/* Makefile */
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = tb_sdram
FILELIST   = project.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
